/* adapter_defines.svh */
/*
 * TileLink-UL SRAM adapter widths and depths
 * Bus geometry, SRAM word address width and the number of outstanding
 * requests shared by every block of the adapter
 */
`ifndef ADAPTER_DEFINES_SVH
`define ADAPTER_DEFINES_SVH

// Bus address width in bits
`define TL_AW 32

// Bus data width, SRAM data width matches it
`define TL_DW 32

// Data bytes per beat
`define TL_DBW 4

// Size field holds log2 of the byte count
`define TL_SZW 2

// Source ID width
`define TL_AIW 8

// SRAM word address, taken from address bits 11 down to 2
`define SRAM_AW 10

// Depth of every FIFO and so the in-flight request limit
`define OUTSTANDING 2

`endif

/* adapter_pkg.sv */
/*
 * TileLink-UL SRAM adapter types
 * Channel opcodes, the request class and the entries of the request
 * and response FIFOs
 */
`include "adapter_defines.svh"

package adapter_pkg;

  // A-channel opcodes with their standard TileLink codes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D-channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Class of a queued request, unknown opcodes fall into OpWrite so they get AccessAck
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } req_op_e;

  // One in-flight request, kept until its D beat completes
  typedef struct packed {
    req_op_e            op;     // Read or write response expected
    logic               error;  // Request was rejected, SRAM never saw it
    logic [`TL_SZW-1:0] size;   // Echoed on d_size
    logic [`TL_AIW-1:0] source; // Echoed on d_source
  } req_t;

  // Read data waiting for the D channel
  typedef struct packed {
    logic [`TL_DW-1:0] data;  // Already masked to the requested bytes
    logic              error; // Uncorrectable SRAM error
  } rsp_t;

endpackage

/* adapter_if.sv */
/*
 * TileLink-UL A and D channel bundles and the SRAM command bundle
 * The ctrl modports belong to the adapter controllers, host to the top level
 */
`timescale 1ns/10ps
`include "adapter_defines.svh"

// A channel, a beat is taken when valid and ready are both high
interface tl_a_if import adapter_pkg::*; ();
  logic               valid;
  tl_a_op_e           opcode;
  logic [`TL_SZW-1:0] size;
  logic [`TL_AIW-1:0] source;
  logic [`TL_AW-1:0]  address;
  logic [`TL_DBW-1:0] mask;
  logic [`TL_DW-1:0]  data;
  logic               ready;

  modport ctrl (input valid, opcode, size, source, address, mask, data, output ready);
  modport host (output valid, opcode, size, source, address, mask, data, input ready);
endinterface

// D channel, clock and reset travel along for the protocol checks
interface tl_d_if import adapter_pkg::*; (input logic clk_i, input logic rst_n_i);
  logic               valid;
  logic               ready;
  tl_d_op_e           opcode;
  logic [`TL_SZW-1:0] size;
  logic [`TL_AIW-1:0] source;
  logic [`TL_DW-1:0]  data;
  logic               error;

  modport ctrl (input clk_i, rst_n_i, ready, output valid, opcode, size, source, data, error);
  modport host (output ready, input valid, opcode, size, source, data, error);
endinterface

// SRAM command, a command is taken when req and gnt are both high
interface sram_cmd_if (input logic clk_i, input logic rst_n_i);
  logic                req;
  logic                gnt;
  logic                we;
  logic [`SRAM_AW-1:0] addr;
  logic [`TL_DW-1:0]   wdata;
  logic [`TL_DW-1:0]   wmask; // Bit mask, one bit per data bit

  modport ctrl (input clk_i, rst_n_i, gnt, output req, we, addr, wdata, wmask);
  modport host (output gnt, input req, we, addr, wdata, wmask);
endinterface

/* sync_fifo.sv */
/*
 * Synchronous FIFO
 * Circular buffer with read and write pointers and an occupancy count.
 * With Pass set, an empty FIFO forwards its input to the read side
 * in the same cycle
 */
`timescale 1ns/10ps

module sync_fifo #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth]; // Storage, payload only
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  count_q;
  logic             empty;
  logic             full;
  logic             flow_through;
  logic             do_push;
  logic             do_pop;

  // Wraps at Depth so non power of two depths work too
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == CntW'(Depth));

  // Data passes straight from writer to reader and never touches storage
  assign flow_through = Pass && empty && wvalid_i && rready_i;

  assign wready_o = ~full;
  assign rvalid_o = ~empty | (Pass & wvalid_i);           // Pass shows new data at once
  assign rdata_o  = (Pass && empty) ? wdata_i : mem_q[rptr_q];

  assign do_push = wvalid_i & ~full & ~flow_through;
  assign do_pop  = rready_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) wptr_q <= ptr_inc(wptr_q);
      if (do_pop) rptr_q <= ptr_inc(rptr_q);
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wptr_q] <= wdata_i;                  // Written entry visible next cycle
  end

  // The writer is expected to respect wready_o
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i |-> wready_o);

  // The reader only pops what is actually there
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rready_i |-> rvalid_o);

endmodule

/* a_channel_ctrl.sv */
/*
 * A-channel controller
 * Checks each request against the TileLink-UL rules and the access
 * policy, turns good requests into SRAM commands and records every
 * accepted beat so its response can be built in order
 */
`timescale 1ns/10ps
`include "adapter_defines.svh"

module a_channel_ctrl import adapter_pkg::*; #(
  parameter bit ByteAccess = 1'b1, // Partial puts allowed
  parameter bit ErrOnWrite = 1'b0, // Every put is rejected
  parameter bit ErrOnRead  = 1'b0  // Every get is rejected
) (
  tl_a_if.ctrl               tl_a,
  sram_cmd_if.ctrl           sram,
  input  logic               reqfifo_wready_i,
  input  logic               sramreqfifo_wready_i,
  output logic               reqfifo_wvalid_o,
  output req_t               reqfifo_wdata_o,
  output logic               sramreqfifo_wvalid_o,
  output logic [`TL_DBW-1:0] sramreqfifo_wdata_o
);

  logic               is_get;
  logic               is_put;
  logic [`TL_DBW-1:0] lanes;     // Byte lanes covered by size and address
  logic               op_err;
  logic               size_err;
  logic               align_err;
  logic               mask_err;
  logic               attr_err;
  logic               policy_err;
  logic               req_error;

  assign is_get = (tl_a.opcode == Get);
  assign is_put = (tl_a.opcode == PutFullData) || (tl_a.opcode == PutPartialData);

  // Lanes for 1, 2 and 4 byte accesses, oversize leaves none
  always_comb begin
    lanes = '0;
    case (tl_a.size)
      2'd0:    lanes = `TL_DBW'(1) << tl_a.address[1:0];
      2'd1:    lanes = tl_a.address[1] ? 4'b1100 : 4'b0011;
      2'd2:    lanes = '1;
      default: lanes = '0;
    endcase
  end

  assign op_err   = ~(is_get | is_put);
  assign size_err = (tl_a.size > 2'd2);

  // Halfwords need bit 0 clear, words need both low bits clear
  assign align_err = ((tl_a.size == 2'd1) && tl_a.address[0]) ||
                     ((tl_a.size == 2'd2) && (tl_a.address[1:0] != 2'b00));

  // No byte outside the lanes, and a full put must fill every lane
  assign mask_err = (|(tl_a.mask & ~lanes)) ||
                    ((tl_a.opcode == PutFullData) && (tl_a.mask != lanes));

  // Without byte access only whole word puts reach the SRAM
  assign attr_err = ~ByteAccess & is_put & ((tl_a.mask != '1) || (tl_a.size != 2'd2));

  assign policy_err = (ErrOnWrite & is_put) | (ErrOnRead & is_get);

  assign req_error = op_err | size_err | align_err | mask_err | attr_err | policy_err;

  // A rejected request is taken without a grant, it never goes to the SRAM
  assign tl_a.ready = (sram.gnt | req_error) & reqfifo_wready_i & sramreqfifo_wready_i;

  assign sram.req  = tl_a.valid & reqfifo_wready_i & ~req_error;
  assign sram.we   = tl_a.valid & is_put;
  assign sram.addr = tl_a.address[`SRAM_AW+1:2];            // Word address

  // Byte mask becomes a bit mask and only enabled bytes carry data
  always_comb begin
    sram.wmask = '0;
    sram.wdata = '0;
    for (int i = 0; i < `TL_DBW; i++) begin
      sram.wmask[8*i +: 8] = {8{tl_a.mask[i]}};
      sram.wdata[8*i +: 8] = (tl_a.mask[i] && sram.we) ? tl_a.data[8*i +: 8] : 8'h00;
    end
  end

  // Every accepted beat is queued, errors included, to keep responses in order
  assign reqfifo_wvalid_o = tl_a.valid & tl_a.ready;
  assign reqfifo_wdata_o  = '{
    op:     is_get ? OpRead : OpWrite, // Unknown opcodes answer with AccessAck
    error:  req_error,
    size:   tl_a.size,
    source: tl_a.source
  };

  // Granted reads park their mask until the data comes back
  assign sramreqfifo_wvalid_o = sram.req & sram.gnt & ~sram.we;
  assign sramreqfifo_wdata_o  = tl_a.mask;

  // Any granted command is a clean request that also lands in the request FIFO
  a_cmd_is_queued: assert property (@(posedge sram.clk_i) disable iff (!sram.rst_n_i)
    (sram.req && sram.gnt) |-> (!req_error && reqfifo_wvalid_o));

endmodule

/* d_channel_ctrl.sv */
/*
 * D-channel controller
 * Builds the response for the request at the head of the request FIFO,
 * masks returning read data and parks it in the response FIFO until
 * the D channel can take it
 */
`timescale 1ns/10ps
`include "adapter_defines.svh"

module d_channel_ctrl import adapter_pkg::*; (
  tl_d_if.ctrl              tl_d,
  input  logic              reqfifo_rvalid_i,
  input  req_t              reqfifo_rdata_i,
  input  logic [`TL_DBW-1:0] sramreqfifo_rdata_i,
  input  logic              rsp_rvalid_i,
  input  rsp_t              rsp_rdata_i,
  input  logic [`TL_DW-1:0] rdata_i,
  input  logic              rvalid_i,
  input  logic              rerror_i,   // Uncorrectable SRAM error
  output logic              reqfifo_rready_o,
  output logic              sramreqfifo_rready_o,
  output logic              rsp_wvalid_o,
  output rsp_t              rsp_wdata_o,
  output logic              rsp_rready_o
);

  logic              head_read;   // Head is a read that went out to the SRAM
  logic              d_ack;
  logic [`TL_DW-1:0] rmask;

  assign head_read = (reqfifo_rdata_i.op == OpRead) & ~reqfifo_rdata_i.error;

  // Writes and rejected requests answer at once, reads wait for their data
  assign tl_d.valid = reqfifo_rvalid_i & (~head_read | rsp_rvalid_i);

  assign tl_d.opcode = (reqfifo_rdata_i.op == OpRead) ? AccessAckData : AccessAck;
  assign tl_d.size   = tl_d.valid ? reqfifo_rdata_i.size : '0;
  assign tl_d.source = tl_d.valid ? reqfifo_rdata_i.source : '0;

  // Request errors and uncorrectable read errors both show up here
  assign tl_d.error = tl_d.valid &
                      (reqfifo_rdata_i.error | (head_read & rsp_rdata_i.error));

  // Only clean reads return data, errored ones return zero
  assign tl_d.data = (tl_d.valid && head_read && !rsp_rdata_i.error) ? rsp_rdata_i.data : '0;

  assign d_ack = tl_d.valid & tl_d.ready;

  assign reqfifo_rready_o = d_ack;                           // Request retires with its D beat
  assign rsp_rready_o     = d_ack & head_read;

  // Byte mask of the oldest outstanding read
  always_comb begin
    rmask = '0;
    for (int i = 0; i < `TL_DBW; i++) begin
      rmask[8*i +: 8] = {8{sramreqfifo_rdata_i[i]}};
    end
  end

  // Read data is stored as soon as it arrives, the SRAM cannot be stalled
  assign rsp_wvalid_o         = rvalid_i & reqfifo_rvalid_i;
  assign sramreqfifo_rready_o = rsp_wvalid_o;               // Mask is done with
  assign rsp_wdata_o = '{
    data:  rdata_i & rmask,                                 // Unrequested lanes read as zero
    error: rerror_i
  };

  // A read return always has its request still waiting in the request FIFO
  a_rvalid_has_req: assert property (@(posedge tl_d.clk_i) disable iff (!tl_d.rst_n_i)
    rvalid_i |-> reqfifo_rvalid_i);

  // Under back-pressure the pending response stays put
  a_d_stable: assert property (@(posedge tl_d.clk_i) disable iff (!tl_d.rst_n_i)
    (tl_d.valid && !tl_d.ready) |=>
      (tl_d.valid && $stable(tl_d.data) && $stable(tl_d.source) && $stable(tl_d.error)));

endmodule

/* sram_adapter_top.sv */
/*
 * TileLink-UL to SRAM adapter
 * Single-beat Get and Put requests in, req/gnt/rvalid SRAM port out,
 * responses returned in request order
 */
`timescale 1ns/10ps
`include "adapter_defines.svh"

module sram_adapter_top import adapter_pkg::*; #(
  parameter bit ByteAccess = 1'b1,
  parameter bit ErrOnWrite = 1'b0,
  parameter bit ErrOnRead  = 1'b0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                a_valid_i,
  input  tl_a_op_e            a_opcode_i,
  input  logic [`TL_SZW-1:0]  a_size_i,
  input  logic [`TL_AIW-1:0]  a_source_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DBW-1:0]  a_mask_i,
  input  logic [`TL_DW-1:0]   a_data_i,
  output logic                a_ready_o,
  input  logic                d_ready_i,
  output logic                d_valid_o,
  output tl_d_op_e            d_opcode_o,
  output logic [`TL_SZW-1:0]  d_size_o,
  output logic [`TL_AIW-1:0]  d_source_o,
  output logic [`TL_DW-1:0]   d_data_o,
  output logic                d_error_o,
  output logic                req_o,
  output logic                we_o,
  output logic [`SRAM_AW-1:0] addr_o,
  output logic [`TL_DW-1:0]   wdata_o,
  output logic [`TL_DW-1:0]   wmask_o,
  input  logic                gnt_i,
  input  logic [`TL_DW-1:0]   rdata_i,
  input  logic                rvalid_i,
  input  logic [1:0]          rerror_i   // Bit 1 uncorrectable, bit 0 correctable
);

  tl_a_if     u_tl_a ();
  tl_d_if     u_tl_d (.clk_i, .rst_n_i);
  sram_cmd_if u_sram (.clk_i, .rst_n_i);

  logic               reqfifo_wvalid, reqfifo_wready, reqfifo_rvalid, reqfifo_rready;
  req_t               reqfifo_wdata, reqfifo_rdata;
  logic               sramreqfifo_wvalid, sramreqfifo_wready, sramreqfifo_rready;
  logic [`TL_DBW-1:0] sramreqfifo_wdata, sramreqfifo_rdata;
  logic               rsp_wvalid, rsp_wready, rsp_rvalid, rsp_rready;
  rsp_t               rsp_wdata, rsp_rdata;

  assign u_tl_a.valid   = a_valid_i;
  assign u_tl_a.opcode  = a_opcode_i;
  assign u_tl_a.size    = a_size_i;
  assign u_tl_a.source  = a_source_i;
  assign u_tl_a.address = a_address_i;
  assign u_tl_a.mask    = a_mask_i;
  assign u_tl_a.data    = a_data_i;
  assign a_ready_o      = u_tl_a.ready;

  assign u_tl_d.ready = d_ready_i;
  assign d_valid_o    = u_tl_d.valid;
  assign d_opcode_o   = u_tl_d.opcode;
  assign d_size_o     = u_tl_d.size;
  assign d_source_o   = u_tl_d.source;
  assign d_data_o     = u_tl_d.data;
  assign d_error_o    = u_tl_d.error;

  assign u_sram.gnt = gnt_i;
  assign req_o      = u_sram.req;
  assign we_o       = u_sram.we;
  assign addr_o     = u_sram.addr;
  assign wdata_o    = u_sram.wdata;
  assign wmask_o    = u_sram.wmask;

  a_channel_ctrl #(.ByteAccess(ByteAccess), .ErrOnWrite(ErrOnWrite), .ErrOnRead(ErrOnRead))
  u_a_channel_ctrl (
    .tl_a (u_tl_a), .sram (u_sram),
    .reqfifo_wready_i (reqfifo_wready), .sramreqfifo_wready_i (sramreqfifo_wready),
    .reqfifo_wvalid_o (reqfifo_wvalid), .reqfifo_wdata_o      (reqfifo_wdata),
    .sramreqfifo_wvalid_o (sramreqfifo_wvalid), .sramreqfifo_wdata_o (sramreqfifo_wdata)
  );

  // Not pass-through, so a D beat never leaves in the cycle its A beat was taken
  sync_fifo #(.Width($bits(req_t)), .Depth(`OUTSTANDING), .Pass(1'b0)) u_req_fifo (
    .clk_i, .rst_n_i,
    .wvalid_i (reqfifo_wvalid), .wready_o (reqfifo_wready), .wdata_i (reqfifo_wdata),
    .rvalid_o (reqfifo_rvalid), .rready_i (reqfifo_rready), .rdata_o (reqfifo_rdata)
  );

  // Read masks only, emptied as read data returns
  sync_fifo #(.Width(`TL_DBW), .Depth(`OUTSTANDING), .Pass(1'b0)) u_sramreq_fifo (
    .clk_i, .rst_n_i,
    .wvalid_i (sramreqfifo_wvalid), .wready_o (sramreqfifo_wready),
    .wdata_i  (sramreqfifo_wdata),  .rvalid_o (),
    .rready_i (sramreqfifo_rready), .rdata_o  (sramreqfifo_rdata)
  );

  // As deep as the read limit so nothing is dropped while d_ready_i is low
  sync_fifo #(.Width($bits(rsp_t)), .Depth(`OUTSTANDING), .Pass(1'b1)) u_rsp_fifo (
    .clk_i, .rst_n_i,
    .wvalid_i (rsp_wvalid), .wready_o (rsp_wready), .wdata_i (rsp_wdata),
    .rvalid_o (rsp_rvalid), .rready_i (rsp_rready), .rdata_o (rsp_rdata)
  );

  d_channel_ctrl u_d_channel_ctrl (
    .tl_d (u_tl_d),
    .reqfifo_rvalid_i (reqfifo_rvalid), .reqfifo_rdata_i (reqfifo_rdata),
    .sramreqfifo_rdata_i (sramreqfifo_rdata),
    .rsp_rvalid_i (rsp_rvalid), .rsp_rdata_i (rsp_rdata),
    .rdata_i, .rvalid_i, .rerror_i (rerror_i[1]),
    .reqfifo_rready_o (reqfifo_rready), .sramreqfifo_rready_o (sramreqfifo_rready),
    .rsp_wvalid_o (rsp_wvalid), .rsp_wdata_o (rsp_wdata), .rsp_rready_o (rsp_rready)
  );

  // Response FIFO space is guaranteed by the in-flight limit
  a_rsp_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_wvalid |-> rsp_wready);

endmodule

/* tb_sram_model.sv */
/*
 * Behavioral SRAM for the adapter testbench
 * Grant follows a random enable from the testbench, reads return one
 * cycle after the grant and can carry an uncorrectable error
 */
`timescale 1ns/10ps
`include "adapter_defines.svh"

module tb_sram_model (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                gnt_en_i,   // Random grant bit from the testbench LFSR
  input  logic                inject_i,   // Flags the read granted in this cycle as bad
  input  logic                req_i,
  input  logic                we_i,
  input  logic [`SRAM_AW-1:0] addr_i,
  input  logic [`TL_DW-1:0]   wdata_i,
  input  logic [`TL_DW-1:0]   wmask_i,
  output logic                gnt_o,
  output logic [`TL_DW-1:0]   rdata_o,
  output logic                rvalid_o,
  output logic [1:0]          rerror_o
);

  logic [`TL_DW-1:0] mem [1 << `SRAM_AW];

  // Every word holds its own address and its inverse, so no two words match
  initial begin
    for (int i = 0; i < (1 << `SRAM_AW); i++) begin
      mem[i] = {6'h2a, 10'(i), 6'h15, ~10'(i)};
    end
  end

  assign gnt_o = gnt_en_i; // Grant never looks at req

  // Bit mask write, untouched bits keep their old value
  always @(posedge clk_i) begin
    if (req_i && gnt_o && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      rerror_o <= 2'b00;
    end else begin
      rvalid_o <= req_i & gnt_o & ~we_i;                    // One cycle read latency
      if (req_i && gnt_o && !we_i) begin
        rdata_o  <= mem[addr_i];
        rerror_o <= {inject_i, 1'b0};                       // Only the uncorrectable bit is used
      end
    end
  end

endmodule

/* tb_sram_adapter.sv */
/*
 * Testbench for the TileLink-UL SRAM adapter
 * Replays the requests of the stimulus file under random grant and
 * d_ready back-pressure and checks each D beat, in order, against the
 * response listed next to its request
 */
`timescale 1ns/10ps
`include "adapter_defines.svh"

module tb_sram_adapter import adapter_pkg::*;;

  // One stimulus line, request fields followed by the expected response
  typedef struct packed {
    logic [2:0]         opcode;
    logic [`TL_AW-1:0]  address;
    logic [`TL_DBW-1:0] mask;
    logic [`TL_DW-1:0]  data;
    logic [`TL_SZW-1:0] size;
    logic [`TL_AIW-1:0] source;
    logic               inject;
    logic [2:0]         exp_opcode;
    logic               exp_error;
    logic [`TL_DW-1:0]  exp_data;
  } stim_t;

  logic                clk_i;
  logic                rst_n_i;
  logic                a_valid;
  tl_a_op_e            a_opcode;
  logic [`TL_SZW-1:0]  a_size;
  logic [`TL_AIW-1:0]  a_source;
  logic [`TL_AW-1:0]   a_address;
  logic [`TL_DBW-1:0]  a_mask;
  logic [`TL_DW-1:0]   a_data;
  logic                a_ready;
  logic                d_ready;
  logic                d_valid;
  tl_d_op_e            d_opcode;
  logic [`TL_SZW-1:0]  d_size;
  logic [`TL_AIW-1:0]  d_source;
  logic [`TL_DW-1:0]   d_data;
  logic                d_error;
  logic                req;
  logic                we;
  logic [`SRAM_AW-1:0] addr;
  logic [`TL_DW-1:0]   wdata;
  logic [`TL_DW-1:0]   wmask;
  logic                gnt;
  logic [`TL_DW-1:0]   rdata;
  logic                rvalid;
  logic [1:0]          rerror;
  logic                gnt_en;         // Random grant for the SRAM model
  logic                inject;         // Error flag travelling with the driven request

  stim_t       stim_q[$];
  stim_t       expect_q[$];            // Accepted requests waiting for their D beat
  stim_t       cur_req;                // Request currently on the A channel
  logic [31:0] lfsr_q = 32'h5c001887;
  int          value_errors = 0;
  int          other_errors = 0;
  int          rsp_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  sram_adapter_top u_sram_adapter_top (
    .clk_i, .rst_n_i,
    .a_valid_i (a_valid), .a_opcode_i (a_opcode), .a_size_i (a_size),
    .a_source_i (a_source), .a_address_i (a_address), .a_mask_i (a_mask),
    .a_data_i (a_data), .a_ready_o (a_ready),
    .d_ready_i (d_ready), .d_valid_o (d_valid), .d_opcode_o (d_opcode),
    .d_size_o (d_size), .d_source_o (d_source), .d_data_o (d_data), .d_error_o (d_error),
    .req_o (req), .we_o (we), .addr_o (addr), .wdata_o (wdata), .wmask_o (wmask),
    .gnt_i (gnt), .rdata_i (rdata), .rvalid_i (rvalid), .rerror_i (rerror)
  );

  tb_sram_model u_sram_model (
    .clk_i, .rst_n_i, .gnt_en_i (gnt_en), .inject_i (inject),
    .req_i (req), .we_i (we), .addr_i (addr), .wdata_i (wdata), .wmask_i (wmask),
    .gnt_o (gnt), .rdata_o (rdata), .rvalid_o (rvalid), .rerror_o (rerror)
  );

  always #50 clk_i = ~clk_i; // 100 ns period

  // Right-shifting Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hd0000001) : (state >> 1);
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [10];
    stim_t       s;
    fd = $fopen("adapter_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open adapter_stimulus.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin      // Skip comments and blank lines
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        if (n != 10) begin
          $display("Stimulus line has %0d fields instead of 10: %s", n, line);
          other_errors++;
        end else begin
          s.opcode     = f[0][2:0];
          s.address    = f[1];
          s.mask       = f[2][3:0];
          s.data       = f[3];
          s.size       = f[4][1:0];
          s.source     = f[5][7:0];
          s.inject     = f[6][0];
          s.exp_opcode = f[7][2:0];
          s.exp_error  = f[8][0];
          s.exp_data   = f[9];
          stim_q.push_back(s);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_request(input stim_t s);
    a_valid   <= 1'b1;
    a_opcode  <= tl_a_op_e'(s.opcode);                    // Unknown codes go out as they are
    a_size    <= s.size;
    a_source  <= s.source;
    a_address <= s.address;
    a_mask    <= s.mask;
    a_data    <= s.data;
    inject    <= s.inject;
    cur_req   <= s;
  endtask

  // Compares one completed D beat with the oldest accepted request
  task automatic check_response();
    stim_t      e;
    logic [2:0] got_op;
    if (expect_q.size() == 0) begin
      $display("D beat at %0t arrived with no request outstanding", $time);
      other_errors++;
      return;
    end
    e = expect_q.pop_front();
    got_op = d_opcode;
    rsp_count++;
    if (got_op != e.exp_opcode) begin
      $display("error at %0t: d_opcode_o = %0h, expected %0h", $time, got_op, e.exp_opcode);
      value_errors++;
    end
    if (d_error != e.exp_error) begin
      $display("error at %0t: d_error_o = %0b, expected %0b", $time, d_error, e.exp_error);
      value_errors++;
    end
    if (d_data != e.exp_data) begin
      $display("error at %0t: d_data_o = %h, expected %h", $time, d_data, e.exp_data);
      value_errors++;
    end
    if (d_source != e.source) begin
      $display("error at %0t: d_source_o = %h, expected %h", $time, d_source, e.source);
      value_errors++;
    end
    if (d_size != e.size) begin
      $display("error at %0t: d_size_o = %0d, expected %0d", $time, d_size, e.size);
      value_errors++;
    end
  endtask

  // Handshakes are judged mid-cycle, where every signal has settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (d_valid && d_ready) check_response();
      if (a_valid && a_ready) expect_q.push_back(cur_req);  // Taken at the next rising edge
    end
  end

  // Random back-pressure on both sides once reset is released
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      lfsr_q = lfsr_step(lfsr_q);
      d_ready <= lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      gnt_en <= lfsr_q[0];
    end
  end

  initial begin
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    a_valid   = 1'b0;
    a_opcode  = Get;
    a_size    = '0;
    a_source  = '0;
    a_address = '0;
    a_mask    = '0;
    a_data    = '0;
    d_ready   = 1'b0;
    gnt_en    = 1'b0;
    inject    = 1'b0;
    cur_req   = '0;
    load_stimulus();
    if (stim_q.size() == 0) begin
      $display("No requests were loaded from the stimulus file");
      other_errors++;
    end
    cycle_limit = 40 * stim_q.size() + 8;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < stim_q.size(); i++) begin
      @(posedge clk_i);
      drive_request(stim_q[i]);
      @(negedge clk_i);
      while (!a_ready) @(negedge clk_i);                  // Hold the beat until it is taken
    end
    @(posedge clk_i);
    a_valid <= 1'b0;
    inject  <= 1'b0;
    wait (rsp_count == stim_q.size());
    repeat (2) @(posedge clk_i);                           // Catch any stray D beat
    $display("Requests %0d, responses %0d, value errors %0d, other errors %0d",
             stim_q.size(), rsp_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Stops a stuck run
  initial begin
    @(posedge clk_i);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d of %0d responses received",
             cycle_count, rsp_count, stim_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

/* adapter_stimulus.txt */
# Hex columns: opcode address mask data size source inject exp_d_opcode exp_d_error exp_d_data
# Opcodes: 0 PutFullData, 1 PutPartialData, 4 Get, others unknown
0 00000010 f 11223344 2 01 0 0 0 00000000
4 00000010 f 00000000 2 02 0 1 0 11223344
1 00000010 4 aabbccdd 2 03 0 0 0 00000000
4 00000010 f 00000000 2 04 0 1 0 11bb3344
1 00000013 8 ee000000 0 05 0 0 0 00000000
4 00000010 f 00000000 2 06 0 1 0 eebb3344
1 00000012 c 55667788 1 07 0 0 0 00000000
4 00000010 f 00000000 2 08 0 1 0 55663344
4 00000010 3 00000000 2 09 0 1 0 00003344
4 00000011 2 00000000 0 0a 0 1 0 00003300
4 00000012 c 00000000 1 0b 0 1 0 55660000
0 00000020 f cafef00d 2 0c 0 0 0 00000000
0 00000022 f 12345678 2 0d 0 0 1 00000000
0 00000020 f 12345678 3 0e 0 0 1 00000000
1 00000020 3 12345678 0 0f 0 0 1 00000000
0 00000020 1 12345678 1 10 0 0 1 00000000
4 00000021 3 00000000 1 11 0 1 1 00000000
2 00000020 f 12345678 2 12 0 0 1 00000000
4 00000020 f 00000000 2 13 0 1 0 cafef00d
4 00000020 f 00000000 2 14 1 1 1 00000000
4 00000010 f 00000000 2 15 0 1 0 55663344
0 000003fc f 0badc0de 2 16 0 0 0 00000000
4 000003fc f 00000000 2 17 0 1 0 0badc0de
0 00000ffc f 76543210 2 18 0 0 0 00000000
4 00000ffc f 00000000 2 19 0 1 0 76543210
4 00000100 f 00000000 2 1a 0 1 0 a84057bf
4 000003fc 8 00000000 2 1b 0 1 0 0b000000
4 00000010 f 00000000 2 ff 0 1 0 55663344

/* src.f */
+incdir+.
adapter_pkg.sv
adapter_if.sv
sync_fifo.sv
a_channel_ctrl.sv
d_channel_ctrl.sv
sram_adapter_top.sv
tb_sram_model.sv
tb_sram_adapter.sv

/* Makefile */
TOP  = tb_sram_adapter
SRCS = $(filter-out +incdir+%,$(shell cat src.f)) adapter_defines.svh

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation completed successfully$$"

clean:
	rm -rf obj_dir

.PHONY: run clean
